//--- Makefile
# Verilator build for the multi-cycle arithmetic unit
# override any variable on the command line, e.g. make sim TOP=mds_tb

VERILATOR ?= verilator
TOP       ?= mds_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --assert --timing --timescale 1ns/1ps
PASS_TEXT ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the status of the pipeline is that of grep, so a missing pass line fails
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/mds_tb_vectors.svh
// one directed row, with the operands and the expected out
typedef struct packed {
  mds_pkg::mds_op_e op;
  mds_pkg::word_t   a;
  mds_pkg::word_t   b;
  mds_pkg::word_t   want;
} vec_t;

vec_t           directed[$];
mds_pkg::word_t lfsr_state = 32'd38;  // random stream seed

task automatic add_row(input mds_pkg::mds_op_e op_i, input mds_pkg::word_t a_i,
                       input mds_pkg::word_t b_i, input mds_pkg::word_t want_i);
  vec_t row;
  row.op   = op_i;
  row.a    = a_i;
  row.b    = b_i;
  row.want = want_i;
  directed.push_back(row);
endtask

task automatic load_directed();
  // shifts of a negative word by 0, 1, 17 and 31
  add_row(mds_pkg::op_sll, 32'h8765_4321, 32'd0, 32'h8765_4321);
  add_row(mds_pkg::op_sll, 32'h8765_4321, 32'd1, 32'h0eca_8642);
  add_row(mds_pkg::op_sll, 32'h8765_4321, 32'd17, 32'h8642_0000);
  add_row(mds_pkg::op_sll, 32'h8765_4321, 32'd31, 32'h8000_0000);
  add_row(mds_pkg::op_srl, 32'h8765_4321, 32'd0, 32'h8765_4321);
  add_row(mds_pkg::op_srl, 32'h8765_4321, 32'd1, 32'h43b2_a190);
  add_row(mds_pkg::op_srl, 32'h8765_4321, 32'd17, 32'h0000_43b2);
  add_row(mds_pkg::op_srl, 32'h8765_4321, 32'd31, 32'h0000_0001);
  add_row(mds_pkg::op_sra, 32'h8765_4321, 32'd0, 32'h8765_4321);
  add_row(mds_pkg::op_sra, 32'h8765_4321, 32'd1, 32'hc3b2_a190);
  add_row(mds_pkg::op_sra, 32'h8765_4321, 32'd17, 32'hffff_c3b2);
  add_row(mds_pkg::op_sra, 32'h8765_4321, 32'd31, 32'hffff_ffff);
  add_row(mds_pkg::op_sra, 32'h7000_0000, 32'd4, 32'h0700_0000);  // zero fill when positive
  // multiplies
  add_row(mds_pkg::op_mul, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
  add_row(mds_pkg::op_mulh, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
  add_row(mds_pkg::op_mulsh, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
  add_row(mds_pkg::op_mul, 32'hffff_fffe, 32'd3, 32'hffff_fffa);
  add_row(mds_pkg::op_mulh, 32'hffff_fffe, 32'd3, 32'h0000_0002);
  add_row(mds_pkg::op_mulsh, 32'hffff_fffe, 32'd3, 32'hffff_ffff);
  add_row(mds_pkg::op_mul, 32'h8000_0000, 32'd2, 32'h0000_0000);
  add_row(mds_pkg::op_mulh, 32'h8000_0000, 32'd2, 32'h0000_0001);
  add_row(mds_pkg::op_mulsh, 32'h8000_0000, 32'd2, 32'hffff_ffff);
  add_row(mds_pkg::op_mul, 32'h0001_0000, 32'hffff_0000, 32'h0000_0000);
  add_row(mds_pkg::op_mulh, 32'h0001_0000, 32'hffff_0000, 32'h0000_ffff);
  add_row(mds_pkg::op_mulsh, 32'h0001_0000, 32'hffff_0000, 32'hffff_ffff);
  add_row(mds_pkg::op_mul, 32'h1234_5678, 32'h10, 32'h2345_6780);
  add_row(mds_pkg::op_mulh, 32'h1234_5678, 32'h10, 32'h0000_0001);
  // divides, all four sign pairs of 7 and 2
  add_row(mds_pkg::op_div, 32'd7, 32'd2, 32'd3);
  add_row(mds_pkg::op_rem, 32'd7, 32'd2, 32'd1);
  add_row(mds_pkg::op_div, 32'hffff_fff9, 32'd2, 32'hffff_fffd);
  add_row(mds_pkg::op_rem, 32'hffff_fff9, 32'd2, 32'hffff_ffff);
  add_row(mds_pkg::op_div, 32'd7, 32'hffff_fffe, 32'hffff_fffd);
  add_row(mds_pkg::op_rem, 32'd7, 32'hffff_fffe, 32'd1);
  add_row(mds_pkg::op_div, 32'hffff_fff9, 32'hffff_fffe, 32'd3);
  add_row(mds_pkg::op_rem, 32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff);
  add_row(mds_pkg::op_div, 32'd100, 32'd7, 32'd14);
  add_row(mds_pkg::op_rem, 32'd100, 32'd7, 32'd2);
  // divide by zero, then the one overflow case
  add_row(mds_pkg::op_div, 32'h0000_1234, 32'd0, 32'hffff_ffff);
  add_row(mds_pkg::op_rem, 32'h0000_1234, 32'd0, 32'h0000_1234);
  add_row(mds_pkg::op_div, 32'hffff_fffb, 32'd0, 32'hffff_ffff);
  add_row(mds_pkg::op_rem, 32'hffff_fffb, 32'd0, 32'hffff_fffb);
  add_row(mds_pkg::op_div, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
  add_row(mds_pkg::op_rem, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
endtask

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic mds_pkg::word_t lfsr_next(input mds_pkg::word_t s);
  return s[0] ? ({1'b0, s[31:1]} ^ 32'h8020_0003) : {1'b0, s[31:1]};
endfunction

function automatic mds_pkg::word_t take_bits(input int n);
  mds_pkg::word_t value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value      = {value[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);  // one step per bit
  end
  return value;
endfunction

// expected out from the simulator's own operators
function automatic mds_pkg::word_t ref_result(input mds_pkg::mds_op_e op_i,
                                              input mds_pkg::word_t a_i,
                                              input mds_pkg::word_t b_i);
  longint unsigned uprod;
  longint          sprod;
  int              sa;
  int              sb;
  uprod = 64'(a_i) * 64'(b_i);
  sprod = longint'($signed(a_i)) * longint'($signed(b_i));
  sa    = $signed(a_i);
  sb    = $signed(b_i);
  case (op_i)
    mds_pkg::op_sll:   return a_i << b_i[4:0];
    mds_pkg::op_srl:   return a_i >> b_i[4:0];
    mds_pkg::op_sra:   return $signed(a_i) >>> b_i[4:0];
    mds_pkg::op_mul:   return uprod[31:0];
    mds_pkg::op_mulh:  return uprod[63:32];
    mds_pkg::op_mulsh: return sprod[63:32];
    mds_pkg::op_div: begin
      if (b_i == '0) return '1;
      if (a_i == 32'h8000_0000 && b_i == '1) return a_i;  // overflow
      return sa / sb;
    end
    mds_pkg::op_rem: begin
      if (b_i == '0) return a_i;
      if (a_i == 32'h8000_0000 && b_i == '1) return '0;
      return sa % sb;
    end
    default: return '0;
  endcase
endfunction

//--- dv/mds_tb.sv
`timescale 1ns/1ps

module mds_tb;

  localparam int half_period = 2;
  localparam int num_random  = 200;
  localparam int max_wait    = 40;  // cycles allowed per operation

  logic             clock;
  logic             reset;
  logic             in_valid;
  mds_pkg::mds_op_e op;
  mds_pkg::word_t   in_a;
  mds_pkg::word_t   in_b;
  logic             busy;
  mds_pkg::word_t   out;
  logic             out_valid;

  int   tests_ok    = 0;
  int   tests_bad   = 0;
  logic table_ready = 1'b0;

  `include "mds_tb_vectors.svh"

  mds_unit #(
    .enable_mul (1),
    .enable_div (1)
  ) dut (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .op        (op),
    .in_a      (in_a),
    .in_b      (in_b),
    .busy      (busy),
    .out       (out),
    .out_valid (out_valid)
  );

  always #(half_period) clock = ~clock;

  // shifts cost one cycle per bit position, the rest a fixed 34
  function automatic int expected_latency(input mds_pkg::mds_op_e op_i,
                                          input mds_pkg::word_t b_i);
    if (op_i inside {mds_pkg::op_sll, mds_pkg::op_srl, mds_pkg::op_sra}) begin
      return int'(b_i[4:0]) + 2;
    end
    return 34;
  endfunction

  task automatic report_test(input int idx, input string what, input bit ok);
    if (ok) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("test %0d %s: %s", idx, what, ok ? "ok" : "FAIL");
  endtask

  task automatic apply_op(input int idx, input mds_pkg::mds_op_e op_i,
                          input mds_pkg::word_t a_i, input mds_pkg::word_t b_i,
                          input mds_pkg::word_t want);
    int cycles;
    int lat;
    bit ok;
    ok       = 1'b1;
    lat      = expected_latency(op_i, b_i);
    op       = op_i;
    in_a     = a_i;
    in_b     = b_i;
    in_valid = 1'b1;
    @(negedge clock);
    in_valid = 1'b0;
    cycles   = 0;  // edges after the one that took the request
    while (!out_valid && cycles < max_wait) begin
      @(negedge clock);
      cycles++;
    end
    if (!out_valid) begin
      $display("no result came back within %0d cycles for %s", max_wait, op_i.name());
      ok = 1'b0;
    end else begin
      assert (cycles == lat) else begin
        $display("** Error at %0t: %s answered after %0d cycles, expected %0d",
                 $time, op_i.name(), cycles, lat);
        ok = 1'b0;
      end
      assert (out == want) else begin
        $display("** Error at %0t: %s a=%h b=%h gave %h, expected %h",
                 $time, op_i.name(), a_i, b_i, out, want);
        ok = 1'b0;
      end
    end
    report_test(idx, $sformatf("%s %h %h", op_i.name(), a_i, b_i), ok);
  endtask

  task automatic check_reset_state(input int idx);
    bit ok;
    ok = 1'b1;
    assert (!busy && !out_valid && out == '0) else begin
      $display("** Error at %0t: after reset busy=%b out_valid=%b out=%h",
               $time, busy, out_valid, out);
      ok = 1'b0;
    end
    report_test(idx, "state after reset", ok);
  endtask

  // second request lands while the multiply runs and must be dropped
  task automatic check_busy_ignore(input int idx);
    int             pulses;
    int             first_cycle;
    mds_pkg::word_t first_out;
    bit             ok;
    ok          = 1'b1;
    pulses      = 0;
    first_cycle = 0;
    first_out   = '0;
    op          = mds_pkg::op_mul;
    in_a        = 32'd1000;
    in_b        = 32'd3000;
    in_valid    = 1'b1;
    for (int c = 1; c <= 2 * max_wait; c++) begin
      @(negedge clock);
      if (out_valid) begin
        pulses++;
        if (pulses == 1) begin
          first_cycle = c - 1;  // counted from the accepting edge
          first_out   = out;
        end
      end
      if (c == 2) begin
        assert (busy) else begin
          $display("** Error at %0t: busy low while a multiply runs", $time);
          ok = 1'b0;
        end
        op       = mds_pkg::op_sll;
        in_a     = 32'h1;
        in_b     = 32'd4;
        in_valid = 1'b1;
      end else begin
        in_valid = 1'b0;
      end
    end
    assert (pulses == 1 && first_cycle == 34 && first_out == 32'd3_000_000) else begin
      $display("** Error at %0t: %0d pulses, first at cycle %0d with %h, expected one at 34",
               $time, pulses, first_cycle, first_out);
      ok = 1'b0;
    end
    report_test(idx, "request while busy", ok);
  endtask

  initial begin
    int               idx;
    mds_pkg::mds_op_e r_op;
    mds_pkg::word_t   r_a;
    mds_pkg::word_t   r_b;
    mds_pkg::word_t   pick;
    clock    = 1'b0;
    reset    = 1'b1;
    in_valid = 1'b0;
    op       = mds_pkg::op_sll;
    in_a     = '0;
    in_b     = '0;
    load_directed();
    table_ready = 1'b1;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    idx   = 0;
    check_reset_state(idx);
    idx++;
    foreach (directed[i]) begin
      apply_op(idx, directed[i].op, directed[i].a, directed[i].b, directed[i].want);
      idx++;
    end
    check_busy_ignore(idx);
    idx++;
    for (int i = 0; i < num_random; i++) begin
      pick = take_bits(3);  // any of the eight ops
      r_op = mds_pkg::mds_op_e'(pick[3:0]);
      r_a  = take_bits(32);
      r_b  = take_bits(32);
      apply_op(idx, r_op, r_a, r_b, ref_result(r_op, r_a, r_b));
      idx++;
    end
    $display("checks: %0d ok, %0d bad", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // three extra rows cover reset and the busy check
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = (directed.size() + num_random + 3) * max_wait * 2 * half_period;
    #(limit_ns);
    $display("watchdog expired after %0d ns, the DUT stopped answering", limit_ns);
    $display("Test failed");
    $finish;
  end

endmodule

//--- hw/mds_divider.sv
`timescale 1ns/1ps

module mds_divider (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  mds_pkg::word_t   a,
  input  mds_pkg::word_t   b,
  input  mds_pkg::mds_op_e op,
  output mds_pkg::word_t   result,
  output logic             done
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_sign
  } state_e;

  state_e           state;
  mds_pkg::shamt_t  count;
  mds_pkg::mds_op_e op_r;
  mds_pkg::word_t   mag_a;    // |a|, 0x8000_0000 stays as is
  mds_pkg::word_t   mag_b;
  logic             neg;      // result needs negating at the end
  mds_pkg::word_t   rem;      // partial remainder
  logic [62:0]      divisor;  // |b| aligned under the remainder msb
  mds_pkg::word_t   quot;
  mds_pkg::word_t   mask;     // quotient bit for this step
  logic             fits;
  mds_pkg::word_t   value;

  assign mag_a = a[31] ? -a : a;
  assign mag_b = b[31] ? -b : b;

  // restoring step: subtract only when the divisor fits
  assign fits = divisor <= {31'b0, rem};

  assign value = (op_r == mds_pkg::op_div) ? quot : rem;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            count <= '0;
            state <= st_run;
          end
        end
        st_run: begin
          if (count == mds_pkg::iter_last) begin
            state <= st_sign;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_sign: begin
          done  <= 1'b1;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && start) begin
      op_r    <= op;
      rem     <= mag_a;
      divisor <= {mag_b, 31'b0};
      quot    <= '0;
      mask    <= 32'h8000_0000;
      if (op == mds_pkg::op_div) begin
        // a zero divisor must leave the all-ones quotient untouched
        neg <= (a[31] ^ b[31]) && (b != '0);
      end else begin
        neg <= a[31];  // remainder takes the dividend sign
      end
    end else if (state == st_run) begin
      if (fits) begin
        rem  <= rem - divisor[31:0];
        quot <= quot | mask;
      end
      divisor <= {1'b0, divisor[62:1]};
      mask    <= {1'b0, mask[31:1]};
    end else if (state == st_sign) begin
      result <= neg ? -value : value;
    end
  end

endmodule

//--- hw/mds_multiplier.sv
`timescale 1ns/1ps

module mds_multiplier (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  mds_pkg::word_t   a,
  input  mds_pkg::word_t   b,
  input  mds_pkg::mds_op_e op,
  output mds_pkg::word_t   result,
  output logic             done
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_pick
  } state_e;

  state_e           state;
  mds_pkg::shamt_t  count;   // index of the multiplier bit in use
  mds_pkg::mds_op_e op_r;
  mds_pkg::dword_t  mcand;   // multiplicand, shifted left each step
  mds_pkg::word_t   mplier;  // multiplier, shifted right each step
  mds_pkg::dword_t  acc;
  logic             last_neg;

  // For the signed high word the top multiplier bit weighs -2^31,
  // so that last partial product is taken away instead of added.
  assign last_neg = (op_r == mds_pkg::op_mulsh) && (count == mds_pkg::iter_last);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            count <= '0;
            state <= st_run;
          end
        end
        st_run: begin
          if (count == mds_pkg::iter_last) begin
            state <= st_pick;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_pick: begin
          done  <= 1'b1;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && start) begin
      op_r   <= op;
      mplier <= b;
      acc    <= '0;
      if (op == mds_pkg::op_mulsh) begin
        mcand <= {{32{a[31]}}, a};  // sign extend
      end else begin
        mcand <= {32'b0, a};
      end
    end else if (state == st_run) begin
      if (mplier[0]) begin
        acc <= last_neg ? acc - mcand : acc + mcand;
      end
      mcand  <= {mcand[62:0], 1'b0};
      mplier <= {1'b0, mplier[31:1]};
    end else if (state == st_pick) begin
      result <= (op_r == mds_pkg::op_mul) ? acc[31:0] : acc[63:32];
    end
  end

endmodule

//--- hw/mds_pkg.sv
package mds_pkg;

  // operand and result word
  typedef logic [31:0] word_t;

  // full product, two words wide
  typedef logic [63:0] dword_t;

  // shift amount, also used as iteration index
  typedef logic [4:0] shamt_t;

  // operation codes seen by the issuer and every unit
  typedef enum logic [3:0] {
    op_sll   = 4'd0,  // shift left logical
    op_srl   = 4'd1,  // shift right, zero fill
    op_sra   = 4'd2,  // shift right, sign fill
    op_mul   = 4'd3,  // low product word
    op_mulh  = 4'd4,  // unsigned high word
    op_mulsh = 4'd5,  // signed x signed high word
    op_div   = 4'd6,  // signed quotient
    op_rem   = 4'd7   // signed remainder
  } mds_op_e;

  // The multiplier and the divider both walk one operand bit per cycle,
  // so both stop after index 31.
  localparam shamt_t iter_last = 5'd31;

endpackage

//--- hw/mds_shifter.sv
`timescale 1ns/1ps

module mds_shifter (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  mds_pkg::word_t   a,
  input  mds_pkg::shamt_t  amount,
  input  mds_pkg::mds_op_e op,
  output mds_pkg::word_t   result,
  output logic             done
);

  typedef enum logic {
    st_idle,
    st_run
  } state_e;

  state_e           state;
  mds_pkg::shamt_t  count;  // bit positions still to go
  mds_pkg::mds_op_e op_r;
  mds_pkg::word_t   value;  // working register

  assign result = value;

  // control, one bit position per cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            count <= amount;
            state <= st_run;
          end
        end
        st_run: begin
          if (count == '0) begin
            done  <= 1'b1;  // amount 0 still costs one cycle
            state <= st_idle;
          end else begin
            count <= count - 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && start) begin
      value <= a;
      op_r  <= op;
    end else if (state == st_run && count != '0) begin
      case (op_r)
        mds_pkg::op_sll: value <= {value[30:0], 1'b0};
        mds_pkg::op_srl: value <= {1'b0, value[31:1]};
        mds_pkg::op_sra: value <= {value[31], value[31:1]};  // keep sign
        default:         value <= value;
      endcase
    end
  end

endmodule

//--- hw/mds_unit.sv
`timescale 1ns/1ps

module mds_unit #(
  parameter int enable_mul = 1,
  parameter int enable_div = 1
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  input  mds_pkg::mds_op_e op,
  input  mds_pkg::word_t   in_a,
  input  mds_pkg::word_t   in_b,
  output logic             busy,
  output mds_pkg::word_t   out,
  output logic             out_valid
);

  typedef enum logic {
    st_idle,
    st_run
  } state_e;

  state_e           state;
  mds_pkg::mds_op_e op_r;     // operation in flight
  logic             accept;
  logic             shift_done;
  logic             mul_done;
  logic             div_done;
  mds_pkg::word_t   shift_result;
  mds_pkg::word_t   mul_result;
  mds_pkg::word_t   div_result;
  logic             fin;      // selected unit has its answer
  mds_pkg::word_t   res;

  assign accept = in_valid && (state == st_idle);  // ignored while busy
  assign busy   = (state == st_run);

  mds_shifter u_shift (
    .clock  (clock),
    .reset  (reset),
    .start  (accept && (op inside {mds_pkg::op_sll, mds_pkg::op_srl, mds_pkg::op_sra})),
    .a      (in_a),
    .amount (in_b[4:0]),
    .op     (op),
    .result (shift_result),
    .done   (shift_done)
  );

  generate
    if (enable_mul != 0) begin : g_mul
      mds_multiplier u_mul (
        .clock  (clock),
        .reset  (reset),
        .start  (accept && (op inside {mds_pkg::op_mul, mds_pkg::op_mulh, mds_pkg::op_mulsh})),
        .a      (in_a),
        .b      (in_b),
        .op     (op),
        .result (mul_result),
        .done   (mul_done)
      );
    end else begin : g_no_mul
      assign mul_result = '0;
      assign mul_done   = 1'b0;
    end

    if (enable_div != 0) begin : g_div
      mds_divider u_div (
        .clock  (clock),
        .reset  (reset),
        .start  (accept && (op inside {mds_pkg::op_div, mds_pkg::op_rem})),
        .a      (in_a),
        .b      (in_b),
        .op     (op),
        .result (div_result),
        .done   (div_done)
      );
    end else begin : g_no_div
      assign div_result = '0;
      assign div_done   = 1'b0;
    end
  endgenerate

  // a disabled or unknown op finishes at once with zero
  always_comb begin
    fin = 1'b1;
    res = '0;
    case (op_r)
      mds_pkg::op_sll, mds_pkg::op_srl, mds_pkg::op_sra: begin
        fin = shift_done;
        res = shift_result;
      end
      mds_pkg::op_mul, mds_pkg::op_mulh, mds_pkg::op_mulsh: begin
        fin = (enable_mul != 0) ? mul_done : 1'b1;
        res = mul_result;
      end
      mds_pkg::op_div, mds_pkg::op_rem: begin
        fin = (enable_div != 0) ? div_done : 1'b1;
        res = div_result;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= st_idle;
      out       <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (in_valid) begin
            state <= st_run;
          end
        end
        st_run: begin
          if (fin) begin
            out       <= res;  // held until next result
            out_valid <= 1'b1;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op_r <= op;
    end
  end

endmodule

//--- list.f
+incdir+dv
hw/mds_pkg.sv
hw/mds_shifter.sv
hw/mds_multiplier.sv
hw/mds_divider.sv
hw/mds_unit.sv
dv/mds_tb.sv
